// ==== common/arm_mem_pkg.sv ====
package arm_mem_pkg;

	localparam int BYTES_PER_WORD = 4;

	// control bits of a single data transfer
	localparam int BIT_PRE = 24;  // set to index before the transfer
	localparam int BIT_UP = 23;   // set to add the offset
	localparam int BIT_BYTE = 22; // set for an unsigned byte
	localparam int BIT_WB = 21;   // set to write the base register back
	localparam int BIT_LOAD = 20; // set for a load and clear for a store

	// register fields
	localparam int RN_HI = 19;
	localparam int RN_LO = 16;
	localparam int RD_HI = 15;
	localparam int RD_LO = 12;

	// instruction class in bits 27:26
	localparam int CLASS_HI = 27;
	localparam int CLASS_LO = 26;
	localparam logic [1:0] CLASS_SDT = 2'b01;

	function automatic logic is_single_transfer(input logic [31:0] insn);
		logic class_ok;
		logic undef;
		class_ok = insn[CLASS_HI:CLASS_LO] == CLASS_SDT;
		// register offset with bit 4 set lands in the undefined space
		undef = insn[25] & insn[4];
		return class_ok & ~undef;
	endfunction

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] insn;
		logic [31:0] op0;        // base
		logic [31:0] op1;        // offset
		logic [31:0] op2;        // store data
		logic        write_reg;
		logic [3:0]  write_num;
		logic [31:0] write_data;
	} stage_in_t;

	typedef struct packed {
		logic        valid;
		logic [3:0]  num;
		logic [31:0] data;
	} wb_t;

	// one request is live while rd or wr is high
	typedef struct packed {
		logic                      rd;
		logic                      wr;
		logic [31:0]               addr;    // word aligned
		logic [BYTES_PER_WORD-1:0] byte_en;
		logic [31:0]               wdata;
	} bus_req_t;

endpackage

// ==== mem_stage/lane_align.sv ====
`timescale 1ns/10ps

module lane_align
	import arm_mem_pkg::*;
(
	input  logic [1:0]                addr_lo,
	input  logic                      byte_xfer,
	input  logic [31:0]               rd_data,
	input  logic [31:0]               st_data,
	output logic [31:0]               ld_data,
	output logic [31:0]               wdata,
	output logic [BYTES_PER_WORD-1:0] byte_en
);

	logic [31:0] rot_half;
	logic [31:0] rot_byte;

	// rotate right by the byte offset in two steps
	assign rot_half = addr_lo[1] ? {rd_data[15:0], rd_data[31:16]} : rd_data;
	assign rot_byte = addr_lo[0] ? {rot_half[7:0], rot_half[31:8]} : rot_half;

	assign ld_data = byte_xfer ? {24'b0, rot_byte[7:0]} : rot_byte;

	// byte stores put the byte on every lane and let byte_en pick one
	assign wdata = byte_xfer ? {BYTES_PER_WORD{st_data[7:0]}} : st_data;

	always_comb begin
		if (byte_xfer) begin
			byte_en = '0;
			byte_en[addr_lo] = 1'b1;
		end else begin
			byte_en = '1;
		end
	end

endmodule

// ==== mem_stage/mem_stage.sv ====
`timescale 1ns/10ps

module mem_stage
	import arm_mem_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  stage_in_t   in,
	input  logic        in_valid,
	input  logic        rw_wait,
	input  logic [31:0] rd_data,
	output logic        in_ready,
	output bus_req_t    bus,
	output wb_t         wb,
	output logic        out_valid,
	output logic [31:0] out_pc,
	output logic [31:0] out_insn
);

	logic                      is_mem;
	logic                      is_load;
	logic                      req;
	logic                      accept;
	logic                      wb2_pend;
	logic [31:0]               eff_addr;
	logic [31:0]               xfer_addr;
	logic [31:0]               ld_data;
	logic [31:0]               st_wdata;
	logic [BYTES_PER_WORD-1:0] st_byte_en;
	logic                      next_valid;
	logic [3:0]                next_num;
	logic [31:0]               next_data;
	logic                      wb_valid;
	logic [3:0]                wb_num;
	logic [31:0]               wb_data;
	logic [3:0]                base_num;
	logic [31:0]               base_addr;

	assign is_mem = is_single_transfer(in.insn);
	assign is_load = in.insn[BIT_LOAD];

	assign eff_addr = in.insn[BIT_UP] ? in.op0 + in.op1 : in.op0 - in.op1;
	assign xfer_addr = in.insn[BIT_PRE] ? eff_addr : in.op0;

	// no request while the base writeback of the previous load is still pending
	assign req = in_valid & is_mem & ~wb2_pend;

	assign bus = '{
		rd: req & is_load,
		wr: req & ~is_load,
		addr: {xfer_addr[31:2], 2'b00},
		byte_en: st_byte_en,
		wdata: st_wdata
	};

	assign in_ready = ~wb2_pend & ~(req & rw_wait);
	assign accept = in_valid & in_ready;

	lane_align u_align (
		.addr_lo  (xfer_addr[1:0]),
		.byte_xfer(in.insn[BIT_BYTE]),
		.rd_data  (rd_data),
		.st_data  (in.op2),
		.ld_data  (ld_data),
		.wdata    (st_wdata),
		.byte_en  (st_byte_en)
	);

	always_comb begin
		next_valid = 1'b0;
		next_num = in.write_num;
		next_data = in.write_data;
		if (wb2_pend) begin
			next_valid = 1'b1;
			next_num = base_num;
			next_data = base_addr;
		end else if (accept && is_mem) begin
			if (is_load) begin
				next_valid = 1'b1;
				next_num = in.insn[RD_HI:RD_LO];
				next_data = ld_data;
			end else begin
				// a store only writes back its base
				next_valid = in.insn[BIT_WB];
				next_num = in.insn[RN_HI:RN_LO];
				next_data = eff_addr;
			end
		end else if (accept) begin
			next_valid = in.write_reg;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
			out_valid <= 1'b0;
			wb2_pend <= 1'b0;
		end else begin
			wb_valid <= next_valid;
			out_valid <= accept;
			wb2_pend <= accept & is_mem & is_load & in.insn[BIT_WB];
		end
	end

	always_ff @(posedge clk) begin
		wb_num <= next_num;
		wb_data <= next_data;
		if (accept) begin
			out_pc <= in.pc;
			out_insn <= in.insn;
			base_num <= in.insn[RN_HI:RN_LO]; // kept for the second load cycle
			base_addr <= eff_addr;
		end
	end

	assign wb = '{valid: wb_valid, num: wb_num, data: wb_data};

endmodule

// ==== design/data_ram.sv ====
`timescale 1ns/10ps

module data_ram
	import arm_mem_pkg::*;
#(
	parameter int MEM_WORDS = 256,
	parameter int WAIT_CYCLES = 2
) (
	input  logic        clk,
	input  logic        arst_n,
	input  bus_req_t    bus,
	output logic        rw_wait,
	output logic [31:0] rd_data
);

	localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	localparam int CW = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES + 1) : 1;

	logic [31:0]   mem [MEM_WORDS];
	logic [AW-1:0] idx;
	logic          req;
	logic          new_req;
	logic          done;
	logic          prev_req;
	logic          prev_done;
	logic [CW-1:0] cnt;

	// MEM_WORDS is a power of two so the low word bits wrap the address
	assign idx = bus.addr[AW+1:2];

	assign req = bus.rd | bus.wr;
	assign new_req = req & (~prev_req | prev_done);
	assign rw_wait = req & (new_req ? (WAIT_CYCLES != 0) : (cnt != '0));
	assign done = req & ~rw_wait;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prev_req <= 1'b0;
			prev_done <= 1'b0;
			cnt <= '0;
		end else begin
			prev_req <= req;
			prev_done <= done;
			if (new_req)
				cnt <= (WAIT_CYCLES == 0) ? '0 : CW'(WAIT_CYCLES - 1);
			else if (cnt != '0)
				cnt <= cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (done && bus.wr) begin
			for (int i = 0; i < BYTES_PER_WORD; i++) begin
				if (bus.byte_en[i])
					mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
			end
		end
	end

	assign rd_data = (done && bus.rd) ? mem[idx] : '0; // valid only in the completing cycle

endmodule

// ==== design/mem_subsys_top.sv ====
`timescale 1ns/10ps

module mem_subsys_top
	import arm_mem_pkg::*;
#(
	parameter int MEM_WORDS = 256,
	parameter int WAIT_CYCLES = 2
) (
	input  logic        clk,
	input  logic        arst_n,
	input  stage_in_t   in,
	input  logic        in_valid,
	output logic        in_ready,
	output wb_t         wb,
	output logic        out_valid,
	output logic [31:0] out_pc,
	output logic [31:0] out_insn
);

	bus_req_t    bus;
	logic        rw_wait;
	logic [31:0] rd_data;

	mem_stage u_stage (
		.clk      (clk),
		.arst_n   (arst_n),
		.in       (in),
		.in_valid (in_valid),
		.rw_wait  (rw_wait),
		.rd_data  (rd_data),
		.in_ready (in_ready),
		.bus      (bus),
		.wb       (wb),
		.out_valid(out_valid),
		.out_pc   (out_pc),
		.out_insn (out_insn)
	);

	data_ram #(
		.MEM_WORDS  (MEM_WORDS),
		.WAIT_CYCLES(WAIT_CYCLES)
	) u_ram (
		.clk    (clk),
		.arst_n (arst_n),
		.bus    (bus),
		.rw_wait(rw_wait),
		.rd_data(rd_data)
	);

endmodule

// ==== tests/mem_subsys_props.sv ====
`timescale 1ns/10ps

module mem_stage_props
	import arm_mem_pkg::*;
(
	input logic     clk,
	input logic     arst_n,
	input bus_req_t bus,
	input logic     rw_wait,
	input logic     in_ready,
	input wb_t      wb
);

	logic        req;
	int unsigned fail_count = 0; // read by the testbench at the end of the run

	assign req = bus.rd | bus.wr;

	rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n) !(bus.rd && bus.wr))
		else begin
			fail_count++;
			$error("bus rd and wr are high together");
		end

	// the held instruction keeps the request steady through its wait states
	req_stable: assert property (@(posedge clk) disable iff (!arst_n)
			(req && rw_wait) |=> $stable(bus))
		else begin
			fail_count++;
			$error("bus request changed during a wait state");
		end

	stall_on_wait: assert property (@(posedge clk) disable iff (!arst_n)
			(req && rw_wait) |-> !in_ready)
		else begin
			fail_count++;
			$error("in_ready high while the bus waits");
		end

	// the first edge after release still sees the reset value
	wb_idle_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !wb.valid)
		else begin
			fail_count++;
			$error("wb valid high right after reset");
		end

endmodule

bind mem_stage mem_stage_props u_props (
	.clk     (clk),
	.arst_n  (arst_n),
	.bus     (bus),
	.rw_wait (rw_wait),
	.in_ready(in_ready),
	.wb      (wb)
);

// ==== tests/tb_mem_subsys.sv ====
`timescale 1ns/10ps

module tb_mem_subsys
	import arm_mem_pkg::*;
();

	localparam int MEM_WORDS = 256;
	localparam int WAIT_CYCLES = 2;
	localparam int PERIOD = 40;
	localparam int N_INSNS = MEM_WORDS + 16 + 8 + 2 * 12 + 32 + 80;
	localparam int LIMIT_NS = (N_INSNS * (WAIT_CYCLES + 4) + 100) * PERIOD;

	typedef struct packed {
		logic        follow; // has to arrive right after the previous writeback
		logic [3:0]  num;
		logic [31:0] data;
	} exp_wb_t;

	typedef struct packed {
		logic [1:0] n;
		exp_wb_t    first;
		exp_wb_t    second;
	} exp_t;

	logic        clk = 1'b0;
	logic        arst_n;
	stage_in_t   in;
	logic        in_valid;
	logic        in_ready;
	wb_t         wb;
	logic        out_valid;
	logic [31:0] out_pc;
	logic [31:0] out_insn;
	logic        acc_seen;
	logic        prev_wb = 1'b0;
	logic [31:0] shadow [MEM_WORDS];
	logic [31:0] pc_next = 32'h100;
	exp_wb_t     wb_q[$];
	logic [63:0] out_q[$];
	int          waited;
	int          errors = 0;
	int          tests_ok = 0;
	int          tests_bad = 0;

	mem_subsys_top #(.MEM_WORDS(MEM_WORDS), .WAIT_CYCLES(WAIT_CYCLES)) DUT (.*);

	always #(PERIOD / 2) clk = ~clk;

	// high at a falling edge when the rising edge before it took the instruction
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			acc_seen <= 1'b0;
		else
			acc_seen <= in_valid & in_ready;
	end

	function automatic void addresses(input stage_in_t x, output logic [31:0] eff,
			output logic [31:0] xfer);
		eff = x.insn[BIT_UP] ? x.op0 + x.op1 : x.op0 - x.op1;
		xfer = x.insn[BIT_PRE] ? eff : x.op0;
	endfunction

	// writebacks that an instruction should produce against the shadow memory
	function automatic exp_t expected_wb(input stage_in_t x);
		exp_t e;
		logic [31:0] eff;
		logic [31:0] xfer;
		logic [63:0] twice;
		logic [31:0] rot;
		e = '0;
		addresses(x, eff, xfer);
		twice = {2{shadow[(xfer >> 2) % MEM_WORDS]}};
		rot = twice[8 * xfer[1:0] +: 32]; // rotate right by the byte offset
		if (!is_single_transfer(x.insn)) begin
			e.n = x.write_reg ? 2'd1 : 2'd0;
			e.first = '{1'b0, x.write_num, x.write_data};
		end else if (x.insn[BIT_LOAD]) begin
			e.n = x.insn[BIT_WB] ? 2'd2 : 2'd1;
			e.first = '{1'b0, x.insn[RD_HI:RD_LO], x.insn[BIT_BYTE] ? {24'b0, rot[7:0]} : rot};
			e.second = '{1'b1, x.insn[RN_HI:RN_LO], eff};
		end else begin
			e.n = x.insn[BIT_WB] ? 2'd1 : 2'd0;
			e.first = '{1'b0, x.insn[RN_HI:RN_LO], eff};
		end
		return e;
	endfunction

	function automatic void store_shadow(input stage_in_t x);
		logic [31:0] eff;
		logic [31:0] xfer;
		int idx;
		addresses(x, eff, xfer);
		idx = (xfer >> 2) % MEM_WORDS;
		if (is_single_transfer(x.insn) && !x.insn[BIT_LOAD]) begin
			if (x.insn[BIT_BYTE])
				shadow[idx][8 * xfer[1:0] +: 8] = x.op2[7:0];
			else
				shadow[idx] = x.op2;
		end
	endfunction

	// ctl holds pre, up, byte, writeback and load in that order
	function automatic logic [31:0] ldst(input logic [4:0] ctl, input logic [3:0] rn,
			input logic [3:0] rd);
		return {4'he, CLASS_SDT, 1'b0, ctl, rn, rd, 12'h000};
	endfunction

	function automatic stage_in_t make_in(input logic [31:0] insn, input logic [31:0] op0,
			input logic [31:0] op1, input logic [31:0] op2);
		stage_in_t x;
		x = '{pc_next, insn, op0, op1, op2, 1'($urandom()), 4'($urandom()), $urandom()};
		pc_next = pc_next + 32'd4;
		return x;
	endfunction

	// base and offset stay small so every address lands in the 256 word window
	function automatic logic [31:0] rand_base();
		return 32'h200 + ($urandom() % 256);
	endfunction

	function automatic logic [31:0] rand_off();
		return $urandom() % 256;
	endfunction

	task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
		if (act_v !== exp_v) begin
			errors++;
			$display("ERROR %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
		end
	endtask

	task automatic issue(input stage_in_t x);
		exp_t e;
		e = expected_wb(x);
		if (e.n != 2'd0)
			wb_q.push_back(e.first);
		if (e.n == 2'd2)
			wb_q.push_back(e.second);
		out_q.push_back({x.pc, x.insn});
		store_shadow(x);
		in = x;
		in_valid = 1'b1;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!acc_seen);
	endtask

	task automatic report(input string name, input int start);
		in_valid = 1'b0;
		while (wb_q.size() != 0 || out_q.size() != 0)
			@(negedge clk);
		repeat (2) @(negedge clk);
		if (errors == start) begin
			tests_ok++;
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: %0d errors", name, errors - start);
		end
	endtask

	always @(negedge clk) begin
		exp_wb_t ew;
		logic [63:0] eo;
		if (arst_n && wb.valid) begin
			if (wb_q.size() == 0) begin
				errors++;
				$display("writeback to r%0d arrived with none expected", wb.num);
			end else begin
				ew = wb_q.pop_front();
				if (ew.follow && !prev_wb) begin
					errors++;
					$display("base writeback to r%0d did not follow the load result", ew.num);
				end
				check("wb.num", {28'd0, ew.num}, {28'd0, wb.num});
				check("wb.data", ew.data, wb.data);
			end
		end
		if (arst_n && out_valid) begin
			if (out_q.size() == 0) begin
				errors++;
				$display("out_valid seen with no instruction outstanding");
			end else begin
				eo = out_q.pop_front();
				check("out_pc", eo[63:32], out_pc);
				check("out_insn", eo[31:0], out_insn);
			end
		end
		prev_wb = wb.valid;
	end

	initial begin
		#(LIMIT_NS);
		$display("run timed out after %0d ns, %0d writebacks never arrived", LIMIT_NS, wb_q.size());
		$display("Test failed");
		$finish;
	end

	initial begin
		int start;
		int kind;
		logic [4:0] ctl;
		logic [31:0] eff;
		logic [31:0] xfer;
		stage_in_t x;
		void'($urandom(32'hef39_ca6a));
		in = '0;
		in_valid = 1'b0;
		arst_n = 1'b0;
		repeat (2) @(negedge clk);
		arst_n = 1'b1;
		// no rising edge has passed since the release, so these are the reset values
		start = errors;
		check("wb.valid", 32'd0, {31'd0, wb.valid});
		check("out_valid", 32'd0, {31'd0, out_valid});
		check("in_ready", 32'd1, {31'd0, in_ready});
		report("reset state", start);

		start = errors;
		for (int i = 0; i < MEM_WORDS; i++)
			issue(make_in(ldst(5'b11000, 4'd1, 4'd2), 32'(i * 4), 32'd0,
				{8'(i), ~8'(i), 8'(i * 7), 8'h5a ^ 8'(i)}));
		report("preload", start);

		start = errors;
		for (int i = 0; i < 16; i++) begin
			ctl = {i[0], i[1], 1'b0, i[2], 1'b1};
			issue(make_in(ldst(ctl, 4'($urandom()), 4'($urandom())), rand_base(), rand_off(),
				$urandom()));
		end
		report("word loads", start);

		start = errors;
		for (int i = 0; i < 8; i++) begin
			ctl = {3'b111, i[2], 1'b1};
			issue(make_in(ldst(ctl, 4'($urandom()), 4'($urandom())), rand_base() & ~32'h3,
				(rand_off() & ~32'h3) | 32'(i % 4), $urandom()));
		end
		report("byte loads", start);

		start = errors;
		for (int i = 0; i < 12; i++) begin
			ctl = {1'($urandom()), 1'($urandom()), i[0], i[1], 1'b0};
			x = make_in(ldst(ctl, 4'($urandom()), 4'd0), rand_base(), rand_off(), $urandom());
			issue(x);
			addresses(x, eff, xfer);
			issue(make_in(ldst(5'b11001, 4'd0, 4'($urandom())), xfer & ~32'h3, 32'd0, $urandom()));
		end
		report("stores and readback", start);

		start = errors;
		for (int i = 0; i < 32; i++) begin
			issue(make_in({4'he, 2'b00, 26'($urandom())}, $urandom(), $urandom(), $urandom()));
			check("stall cycles", 32'd1, 32'(waited));
		end
		report("pass-through", start);

		start = errors;
		for (int i = 0; i < 80; i++) begin
			kind = $urandom() % 3;
			ctl = {4'($urandom()), kind == 0};
			if (kind == 2)
				x = make_in({4'he, 2'b00, 26'($urandom())}, $urandom(), $urandom(), $urandom());
			else
				x = make_in(ldst(ctl, 4'($urandom()), 4'($urandom())), rand_base(), rand_off(),
					$urandom());
			issue(x);
		end
		report("wait-state mix", start);

		if (DUT.u_stage.u_props.fail_count != 0) begin
			errors += DUT.u_stage.u_props.fail_count;
			$display("%0d property failures on the stage handshake or bus",
				DUT.u_stage.u_props.fail_count);
		end
		$display("summary: %0d tests ok, %0d tests failed, %0d errors", tests_ok, tests_bad, errors);
		if (errors == 0 && tests_bad == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== compile.f ====
common/arm_mem_pkg.sv
mem_stage/lane_align.sv
mem_stage/mem_stage.sv
design/data_ram.sv
design/mem_subsys_top.sv
tests/mem_subsys_props.sv
tests/tb_mem_subsys.sv

// ==== Makefile ====
TOP = tb_mem_subsys

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test failed" sim.log || ! grep -q "Test passed" sim.log; then \
		echo "simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
